// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= a10LoaderTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// ==== a10Loader.sv ====
// A10 load file loader

`timescale 1ns/1ps

module a10Loader (
  input  logic                clk,
  input  logic                arstN,
  input  logic                charValid,
  input  loadFormatPkg::tChar charData,
  output logic                memWe,
  output kl10WordPkg::tAddr   memAddr,
  output kl10WordPkg::tWord   memData,
  output logic                busy,
  output logic                startValid,
  output kl10WordPkg::tAddr   startAddr,
  output logic                checksumError
);

  // Characters offered during a fill are dropped
  wire charTaken = charValid && !busy;

  // Decode to execute
  wire                          lineStart;
  loadFormatPkg::tRecKind       lineKind;
  wire                          fieldValid;
  loadFormatPkg::tField         fieldValue;
  wire                          lineEnd;

  // Execute to result
  wire                          wordWe;
  kl10WordPkg::tAddr            wordAddr;
  kl10WordPkg::tWord            wordData;
  wire                          zeroReq;
  kl10WordPkg::tAddr            zeroAddr;
  kl10WordPkg::tZeroCount       zeroCount;
  wire                          startSet;
  kl10WordPkg::tAddr            startAddrIn;

  fieldDecoder uDecode (
    .clk, .arstN,
    .charValid(charTaken), .charData,
    .lineStart, .lineKind, .fieldValid, .fieldValue, .lineEnd
  );

  recordSequencer uExecute (
    .clk, .arstN,
    .lineStart, .lineKind, .fieldValid, .fieldValue, .lineEnd,
    .wordWe, .wordAddr, .wordData,
    .zeroReq, .zeroAddr, .zeroCount,
    .startSet, .startAddrIn, .checksumError
  );

  memWriter uResult (
    .clk, .arstN,
    .wordWe, .wordAddr, .wordData,
    .zeroReq, .zeroAddr, .zeroCount,
    .startSet, .startAddrIn,
    .memWe, .memAddr, .memData, .busy, .startValid, .startAddr
  );

endmodule

// ==== a10LoaderTb.sv ====
// A10 loader testbench

`timescale 1ns/1ps

module a10LoaderTb;

  logic                 clk;
  logic                 arstN;
  logic                 charValid;
  loadFormatPkg::tChar  charData;
  logic                 memWe;
  kl10WordPkg::tAddr    memAddr;
  kl10WordPkg::tWord    memData;
  logic                 busy;
  logic                 startValid;
  kl10WordPkg::tAddr    startAddr;
  logic                 checksumError;

  // Character stream and the writes it must produce
  loadFormatPkg::tChar  chars[$];
  kl10WordPkg::tAddr    expAddr[$];
  kl10WordPkg::tWord    expData[$];
  // Per line {checksumError, startValid, startAddr} once the line has settled
  logic [19:0]          lineFlags[$];
  logic [15:0]          lfsr;
  loadFormatPkg::tField lineSum;
  logic                 errSeen;
  logic                 startSeen;
  kl10WordPkg::tAddr    startExp;
  int                   zeroTotal;
  int                   cycleCount;
  int                   cycleLimit;

  a10Loader uut (
    .clk, .arstN, .charValid, .charData,
    .memWe, .memAddr, .memData, .busy, .startValid, .startAddr, .checksumError
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic abortRun();
    $display("Some tests failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [35:0] got, input logic [35:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  // Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [35:0] randBits(input int n);
    logic [35:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[34:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Load file builder
  ////////////////////////////////////////

  // CR LF plus the flag values due after it
  task automatic putBreak();
    chars.push_back(loadFormatPkg::CHAR_CR);
    chars.push_back(loadFormatPkg::CHAR_LF);
    lineFlags.push_back({errSeen, startSeen, startExp});
  endtask

  // Six-bit groups high first with leading zero groups dropped
  task automatic putField(input loadFormatPkg::tField v, input bit last);
    logic [5:0] grp [3];
    grp[0] = {2'b00, v[15:12]};
    grp[1] = v[11:6];
    grp[2] = v[5:0];
    // Stray blank now and then
    if (randBits(3) == '0) begin
      chars.push_back(loadFormatPkg::CHAR_SPACE);
    end
    for (int i = 0; i < 3; i++) begin
      if (i == 2 || grp[i] != '0 || (i == 1 && grp[0] != '0)) begin
        // Groups below octal 75 get octal 100 added
        chars.push_back((grp[i] < 6'o75) ? {1'b1, grp[i]} : {1'b0, grp[i]});
      end
    end
    lineSum = lineSum + v;
    if (last) begin
      putBreak();
    end else begin
      chars.push_back(loadFormatPkg::CHAR_COMMA);
    end
  endtask

  // Type letter then a blank
  task automatic putType(input loadFormatPkg::tChar kind);
    chars.push_back(kind);
    chars.push_back((randBits(1) != '0) ? loadFormatPkg::CHAR_TAB : loadFormatPkg::CHAR_SPACE);
    lineSum = '0;
  endtask

  // Negated sum closes the line and the bad line has bit 0 flipped
  task automatic putChecksum(input bit corrupt);
    errSeen = errSeen || corrupt;
    putField(-lineSum ^ {15'd0, corrupt}, 1'b1);
  endtask

  // T line where a word count of 0 makes it the transfer line
  task automatic loadLine(input int nWords, input bit corrupt);
    kl10WordPkg::tAddr a;
    kl10WordPkg::tWord d;
    a = kl10WordPkg::tAddr'(randBits(18));
    putType(loadFormatPkg::CHAR_T);
    // High address bits ride in the word count
    putField({a[17:16], 14'(nWords)}, 1'b0);
    putField(a[15:0], 1'b0);
    if (nWords == 0) begin
      startSeen = 1'b1;
      startExp  = a;
    end
    for (int i = 0; i < nWords; i++) begin
      d = randBits(36);
      putField(d[15:0], 1'b0);
      putField(d[31:16], 1'b0);
      putField({12'h000, d[35:32]}, 1'b0);
      expAddr.push_back(a);
      expData.push_back(d);
      a = a + 18'd1;
    end
    putChecksum(corrupt);
  endtask

  // Z line with a fill of 1 to 16 words
  task automatic zeroLine(input bit corrupt);
    kl10WordPkg::tAddr a;
    int                n;
    a = kl10WordPkg::tAddr'(randBits(18));
    n = int'(randBits(4)) + 1;
    putType(loadFormatPkg::CHAR_Z);
    putField({a[17:16], 14'd1}, 1'b0);
    putField(a[15:0], 1'b0);
    putField(16'(n), 1'b0);
    putChecksum(corrupt);
    zeroTotal += n;
    for (int i = 0; i < n; i++) begin
      expAddr.push_back(a);
      expData.push_back('0);
      a = a + 18'd1;
    end
  endtask

  ////////////////////////////////////////
  // Driving and monitoring
  ////////////////////////////////////////

  task automatic sendChar(input loadFormatPkg::tChar c);
    charValid = 1'b1;
    charData  = c;
    @(posedge clk);
    #1;
    charValid = 1'b0;
  endtask

  // Three idle cycles after a line end and then wait out any fill
  task automatic waitSettled();
    repeat (3) @(posedge clk);
    #1;
    while (busy) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Registered write port sampled mid-cycle
  always @(negedge clk) begin
    if (arstN && memWe) begin
      if (expAddr.size() == 0) begin
        $display("Error: memory write to %o that no line asked for", memAddr);
        abortRun();
      end else begin
        checkValue("memAddr", memAddr, expAddr.pop_front());
        checkValue("memData", memData, expData.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the load did not finish within %0d cycles", cycleLimit);
      abortRun();
    end
  end

  initial begin
    string       header;
    logic [19:0] flags;
    header     = "; KL10 DIAGNOSTIC LOAD FILE";
    clk        = 1'b0;
    arstN      = 1'b0;
    charValid  = 1'b0;
    charData   = '0;
    lfsr       = 16'd74;
    errSeen    = 1'b0;
    startSeen  = 1'b0;
    startExp   = '0;
    zeroTotal  = 0;
    cycleCount = 0;
    // Header and a blank line that the loader ignores
    for (int i = 0; i < header.len(); i++) begin
      chars.push_back(loadFormatPkg::tChar'(header.getc(i)));
    end
    putBreak();
    putBreak();
    // Transfer at line 30 and bad checksum at line 36
    for (int n = 0; n < 38; n++) begin
      if (n == 30) begin
        loadLine(0, 1'b0);
      end else if (randBits(2) == '0) begin
        zeroLine(n == 36);
      end else begin
        loadLine(int'(randBits(3)) + 1, n == 36);
      end
    end
    cycleLimit = 2 * (chars.size() + zeroTotal) + 200;
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;
    checkValue("memWe", memWe, 1'b0);
    checkValue("busy", busy, 1'b0);
    checkValue("startValid", startValid, 1'b0);
    checkValue("checksumError", checksumError, 1'b0);
    for (int i = 0; i < chars.size(); i++) begin
      sendChar(chars[i]);
      if (chars[i] == loadFormatPkg::CHAR_CR || chars[i] == loadFormatPkg::CHAR_LF) begin
        waitSettled();
      end
      if (chars[i] == loadFormatPkg::CHAR_LF) begin
        flags = lineFlags.pop_front();
        checkValue("checksumError", checksumError, flags[19]);
        checkValue("startValid", startValid, flags[18]);
        if (flags[18]) begin
          checkValue("startAddr", startAddr, flags[17:0]);
        end
      end
    end
    repeat (4) @(posedge clk);
    if (expAddr.size() != 0) begin
      $display("Error: %0d expected writes never appeared", expAddr.size());
      abortRun();
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== a10Loader_properties.sv ====
// A10 loader assertions

`timescale 1ns/1ps

module a10LoaderProperties (
  input logic              clk,
  input logic              arstN,
  input logic              memWe,
  input kl10WordPkg::tAddr memAddr,
  input kl10WordPkg::tWord memData,
  input logic              busy,
  input logic              startValid
);

  // Start address holds until reset
  startHeld: assert property (@(posedge clk) disable iff (!arstN) !$fell(startValid))
    else $error("startValid dropped after being set");

  // Fill ends right after its last zero write
  busyEnd: assert property (@(posedge clk) disable iff (!arstN)
    $fell(busy) |-> $past(memWe))
    else $error("busy fell without a write in the cycle before");

  // No X on the write port
  writeKnown: assert property (@(posedge clk) disable iff (!arstN)
    memWe |-> !$isunknown({memAddr, memData}))
    else $error("memAddr or memData unknown during a write");

endmodule

bind a10Loader a10LoaderProperties uProps (
  .clk, .arstN, .memWe, .memAddr, .memData, .busy, .startValid
);

// ==== fieldDecoder.sv ====
// Load line field decoder

`timescale 1ns/1ps

module fieldDecoder (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   charValid,
  input  loadFormatPkg::tChar    charData,
  output logic                   lineStart,
  output loadFormatPkg::tRecKind lineKind,
  output logic                   fieldValid,
  output loadFormatPkg::tField   fieldValue,
  output logic                   lineEnd
);

  // Waiting for a type letter, inside fields, or discarding a line
  typedef enum logic [1:0] {S_TYPE, S_FIELD, S_SKIP} tDecState;

  tDecState             state;
  loadFormatPkg::tField acc;
  logic                 isLineEnd;
  logic                 isBlank;
  logic                 isComma;

  ////////////////////////////////////////
  // Character classes
  ////////////////////////////////////////

  always_comb begin
    isLineEnd = (charData == loadFormatPkg::CHAR_CR) || (charData == loadFormatPkg::CHAR_LF);
    isBlank   = (charData == loadFormatPkg::CHAR_SPACE) || (charData == loadFormatPkg::CHAR_TAB);
    isComma   = (charData == loadFormatPkg::CHAR_COMMA);
  end

  ////////////////////////////////////////
  // Line FSM and strobes
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state      <= S_TYPE;
      lineStart  <= 1'b0;
      lineKind   <= loadFormatPkg::IDLE;
      fieldValid <= 1'b0;
      lineEnd    <= 1'b0;
    end else begin
      lineStart  <= 1'b0;
      fieldValid <= 1'b0;
      lineEnd    <= 1'b0;
      if (charValid) begin
        unique case (state)
          S_TYPE: begin
            // Blank lines and the LF of a CR LF pair fall through here
            if (!isLineEnd && !isBlank) begin
              lineStart <= 1'b1;
              if (charData == loadFormatPkg::CHAR_Z) begin
                lineKind <= loadFormatPkg::ZERO;
                state    <= S_FIELD;
              end else if (charData == loadFormatPkg::CHAR_T) begin
                lineKind <= loadFormatPkg::LOAD;
                state    <= S_FIELD;
              end else begin
                // Header and unknown records
                lineKind <= loadFormatPkg::SKIP;
                state    <= S_SKIP;
              end
            end
          end
          S_FIELD: begin
            // Comma or line end closes the open field
            if (isComma || isLineEnd) begin
              fieldValid <= 1'b1;
              lineEnd    <= isLineEnd;
            end
            if (isLineEnd) begin
              state <= S_TYPE;
            end
          end
          S_SKIP: begin
            if (isLineEnd) begin
              state <= S_TYPE;
            end
          end
          default: state <= S_TYPE;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Field accumulator
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (charValid) begin
      if (state == S_TYPE) begin
        acc <= '0;
      end else if (state == S_FIELD) begin
        if (isComma || isLineEnd) begin
          fieldValue <= acc;
          acc        <= '0;
        end else if (!isBlank) begin
          // Six bits per character, most significant group first
          acc <= loadFormatPkg::tField'({acc, charData[loadFormatPkg::FIELD_BITS-1:0]});
        end
      end
    end
  end

endmodule

// ==== kl10WordPkg.sv ====
// KL10 memory word definitions

package kl10WordPkg;

  // Half-word width, also the width of a word address
  localparam int HALF_BITS = 18;

  // Full word is two half-words
  localparam int WORD_BITS = 2 * HALF_BITS;

  typedef logic [HALF_BITS-1:0] tHalfWord;
  typedef logic [WORD_BITS-1:0] tWord;

  // Word address, one half-word wide
  typedef tHalfWord tAddr;

  // High address bits live in bits 15:14 of the word count field
  localparam int ADDR_HI_BITS = 2;

  // What is left of the word count field below them
  localparam int WC_BITS = 16 - ADDR_HI_BITS;

  // Zero fill length, one bit wider than a field to hold 64K
  typedef logic [16:0] tZeroCount;

endpackage

// ==== loadFormatPkg.sv ====
// Load line format definitions

package loadFormatPkg;

  ////////////////////////////////////////
  // Character and field types
  ////////////////////////////////////////

  // One character of the ASCIIized load file
  typedef logic [6:0] tChar;

  // One un-ASCIIized field, also the width of the line checksum
  typedef logic [15:0] tField;

  // Data bits carried by a single character
  localparam int FIELD_BITS = 6;

  // Record type letters and the field separator
  localparam tChar CHAR_Z     = 7'h5A;
  localparam tChar CHAR_T     = 7'h54;
  localparam tChar CHAR_COMMA = 7'h2C;

  // Whitespace and line end codes
  localparam tChar CHAR_LF    = 7'h0A;
  localparam tChar CHAR_CR    = 7'h0D;
  localparam tChar CHAR_SPACE = 7'h20;
  localparam tChar CHAR_TAB   = 7'h09;

  ////////////////////////////////////////
  // Record kinds
  ////////////////////////////////////////

  // Kind of the line being decoded, fixed by its first character
  typedef enum logic [1:0] {IDLE, ZERO, LOAD, SKIP} tRecKind;

  // Three 16-bit fields build one 36-bit word
  localparam int FIELDS_PER_WORD = 3;

  // A zero count field of 0 stands for 64K words
  localparam int ZERO_ALL_COUNT = 65536;

endpackage

// ==== memWriter.sv ====
// Memory write port and zero fill

`timescale 1ns/1ps

module memWriter (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   wordWe,
  input  kl10WordPkg::tAddr      wordAddr,
  input  kl10WordPkg::tWord      wordData,
  input  logic                   zeroReq,
  input  kl10WordPkg::tAddr      zeroAddr,
  input  kl10WordPkg::tZeroCount zeroCount,
  input  logic                   startSet,
  input  kl10WordPkg::tAddr      startAddrIn,
  output logic                   memWe,
  output kl10WordPkg::tAddr      memAddr,
  output kl10WordPkg::tWord      memData,
  output logic                   busy,
  output logic                   startValid,
  output kl10WordPkg::tAddr      startAddr
);

  // High in every cycle that carries a fill write
  logic                   fillBusy;
  // Fill writes still to come after the current one
  kl10WordPkg::tZeroCount fillLeft;

  // Busy covers the request cycle so the source sees it early
  always_comb busy = zeroReq || fillBusy;

  ////////////////////////////////////////
  // Write strobe and fill counter
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWe      <= 1'b0;
      fillBusy   <= 1'b0;
      fillLeft   <= '0;
      startValid <= 1'b0;
    end else begin
      memWe <= 1'b0;
      if (wordWe) begin
        memWe <= 1'b1;
      end else if (zeroReq) begin
        // First fill write goes out next cycle
        memWe    <= 1'b1;
        fillBusy <= 1'b1;
        fillLeft <= zeroCount - 1'b1;
      end else if (fillBusy) begin
        if (fillLeft != '0) begin
          memWe    <= 1'b1;
          fillLeft <= fillLeft - 1'b1;
        end else begin
          fillBusy <= 1'b0;
        end
      end
      // Start address stays valid until reset
      if (startSet) begin
        startValid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Address and data
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wordWe) begin
      memAddr <= wordAddr;
      memData <= wordData;
    end else if (zeroReq) begin
      memAddr <= zeroAddr;
      memData <= '0;
    end else if (fillBusy && (fillLeft != '0)) begin
      // Ascending addresses, data held at zero
      memAddr <= memAddr + 1'b1;
    end
    if (startSet) begin
      startAddr <= startAddrIn;
    end
  end

endmodule

// ==== recordSequencer.sv ====
// Z and T record sequencer

`timescale 1ns/1ps

module recordSequencer (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   lineStart,
  input  loadFormatPkg::tRecKind lineKind,
  input  logic                   fieldValid,
  input  loadFormatPkg::tField   fieldValue,
  input  logic                   lineEnd,
  output logic                   wordWe,
  output kl10WordPkg::tAddr      wordAddr,
  output kl10WordPkg::tWord      wordData,
  output logic                   zeroReq,
  output kl10WordPkg::tAddr      zeroAddr,
  output kl10WordPkg::tZeroCount zeroCount,
  output logic                   startSet,
  output kl10WordPkg::tAddr      startAddrIn,
  output logic                   checksumError
);

  // Field position, saturating at 3
  // 0 word count, 1 address, 2 first data field, 3 any later field
  logic [1:0]                            fieldNum;
  // Field position within the word being built
  logic [1:0]                            phase;
  logic [kl10WordPkg::WC_BITS-1:0]       wordsLeft;
  logic                                  isTransfer;
  logic [kl10WordPkg::ADDR_HI_BITS-1:0]  addrHi;
  kl10WordPkg::tAddr                     curAddr;
  loadFormatPkg::tField                  lowPart;
  loadFormatPkg::tField                  midPart;
  loadFormatPkg::tField                  countField;
  loadFormatPkg::tField                  sum;
  loadFormatPkg::tField                  sumNext;
  logic                                  dataField;
  logic                                  wordDone;

  ////////////////////////////////////////
  // Field classification
  ////////////////////////////////////////

  always_comb begin
    // Running line sum including the field closing this cycle
    sumNext   = sum + (fieldValid ? fieldValue : '0);
    // Data fields only while the word count has words left
    dataField = fieldValid && (lineKind == loadFormatPkg::LOAD) &&
                (fieldNum >= 2'd2) && (wordsLeft != '0);
    wordDone  = dataField && (phase == 2'(loadFormatPkg::FIELDS_PER_WORD - 1));
  end

  ////////////////////////////////////////
  // Control and strobes
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      fieldNum      <= '0;
      phase         <= '0;
      wordsLeft     <= '0;
      isTransfer    <= 1'b0;
      sum           <= '0;
      wordWe        <= 1'b0;
      zeroReq       <= 1'b0;
      startSet      <= 1'b0;
      checksumError <= 1'b0;
    end else begin
      wordWe   <= wordDone;
      zeroReq  <= 1'b0;
      startSet <= 1'b0;
      if (lineStart) begin
        fieldNum  <= '0;
        phase     <= '0;
        wordsLeft <= '0;
        sum       <= '0;
      end else begin
        sum <= sumNext;
        if (fieldValid && (fieldNum != 2'd3)) begin
          fieldNum <= fieldNum + 2'd1;
        end
        // Word count without the high address bits
        if (fieldValid && (fieldNum == 2'd0)) begin
          wordsLeft  <= fieldValue[kl10WordPkg::WC_BITS-1:0];
          isTransfer <= (fieldValue[kl10WordPkg::WC_BITS-1:0] == '0);
        end
        if (wordDone) begin
          phase     <= '0;
          wordsLeft <= wordsLeft - 1'b1;
        end else if (dataField) begin
          phase <= phase + 2'd1;
        end
        if (lineEnd) begin
          // Negated checksum brings the line total to zero
          if (sumNext != '0) begin
            checksumError <= 1'b1;
          end
          zeroReq  <= (lineKind == loadFormatPkg::ZERO);
          startSet <= (lineKind == loadFormatPkg::LOAD) && isTransfer;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Address and data path
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fieldValid && (fieldNum == 2'd0)) begin
      addrHi <= fieldValue[15 -: kl10WordPkg::ADDR_HI_BITS];
    end
    if (fieldValid && (fieldNum == 2'd1)) begin
      curAddr <= {addrHi, fieldValue};
    end
    // Z lines carry the fill length in the first data field
    if (fieldValid && (fieldNum == 2'd2)) begin
      countField <= fieldValue;
    end
    if (dataField && (phase == 2'd0)) begin
      lowPart <= fieldValue;
    end
    if (dataField && (phase == 2'd1)) begin
      midPart <= fieldValue;
    end
    if (wordDone) begin
      // Bits 0-3, then 4-19, then 20-35
      wordData <= {fieldValue[3:0], midPart, lowPart};
      wordAddr <= curAddr;
      curAddr  <= curAddr + 1'b1;
    end
    if (lineEnd) begin
      zeroAddr    <= curAddr;
      startAddrIn <= curAddr;
      zeroCount   <= (countField == '0) ?
                     kl10WordPkg::tZeroCount'(loadFormatPkg::ZERO_ALL_COUNT) :
                     {1'b0, countField};
    end
  end

endmodule

// ==== sources.f ====
loadFormatPkg.sv
kl10WordPkg.sv
fieldDecoder.sv
recordSequencer.sv
memWriter.sv
a10Loader.sv
a10Loader_properties.sv
a10LoaderTb.sv
